/* src/cache_pkg.sv */
// unified cache shared definitions

package cache_pkg;

	// ----------------------------------------------------------------------
	// sizes
	// ----------------------------------------------------------------------

	// port side, word addressed
	localparam int ADDR_WIDTH = 24;
	localparam int DATA_WIDTH = 32;
	localparam int SEL_WIDTH = DATA_WIDTH / 8;

	// line geometry, 2^LINE_SIZE words per line
	localparam int LINE_SIZE = 2;
	localparam int LINE_WORDS = 1 << LINE_SIZE;
	localparam int LINE_WIDTH = DATA_WIDTH * LINE_WORDS;

	// direct mapped, 16 lines
	localparam int INDEX_WIDTH = 4;
	localparam int TAG_WIDTH = ADDR_WIDTH - INDEX_WIDTH - LINE_SIZE;

	// wishbone carries one whole line per beat
	localparam int WB_ADR_WIDTH = ADDR_WIDTH - LINE_SIZE;
	localparam int WB_SEL_WIDTH = SEL_WIDTH * LINE_WORDS;

	// ----------------------------------------------------------------------
	// structs
	// ----------------------------------------------------------------------

	typedef struct packed {
		logic                  valid;
		logic                  we;
		logic [ADDR_WIDTH-1:0] addr;
		logic [DATA_WIDTH-1:0] wdata;
		logic [SEL_WIDTH-1:0]  sel;
	} cache_req_t;

	typedef struct packed {
		logic                    stb;
		logic                    we;
		logic [WB_ADR_WIDTH-1:0] adr;
		logic [LINE_WIDTH-1:0]   dat;
		logic [WB_SEL_WIDTH-1:0] sel;
	} wb_req_t;

	// 1 + 18 + 128 = 147 bits
	typedef struct packed {
		logic                  valid;
		logic [TAG_WIDTH-1:0]  tag;
		logic [LINE_WIDTH-1:0] data;
	} line_entry_t;

	typedef struct packed {
		logic                   en;
		logic                   we;
		logic [INDEX_WIDTH-1:0] index;
		line_entry_t            wdata;
	} ram_cmd_t;

	typedef enum logic [2:0] {
		IDLE,
		LOOKUP,
		REFILL,
		WRITE,
		DONE
	} port_state_t;

endpackage

/* src/cache_line_ram.sv */
// dual-port cache line RAM

`timescale 1ns/10ps

module cache_line_ram (
	input  logic                   clk,
	input  logic                   RESET_INIT_RAM,
	input  cache_pkg::ram_cmd_t    port0_cmd_i,
	output cache_pkg::line_entry_t port0_rdata_o,
	input  cache_pkg::ram_cmd_t    port1_cmd_i,
	output cache_pkg::line_entry_t port1_rdata_o,
	output logic                   init_busy_o
);

	cache_pkg::line_entry_t mem [1 << cache_pkg::INDEX_WIDTH];

	logic [cache_pkg::INDEX_WIDTH-1:0] init_cnt;
	cache_pkg::ram_cmd_t cmd0;
	cache_pkg::ram_cmd_t cmd1;

	// ----------------------------------------------------------------------
	// valid sweep after reset
	// ----------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (RESET_INIT_RAM) begin
			init_busy_o <= 1'b1;
			init_cnt <= '0;
		end else if (init_busy_o) begin
			init_cnt <= init_cnt + 1'b1;
			if (init_cnt == {cache_pkg::INDEX_WIDTH{1'b1}}) begin
				init_busy_o <= 1'b0;
			end
		end
	end

	// sweep takes port 0, port 1 is held off
	always_comb begin
		cmd0 = port0_cmd_i;
		cmd1 = port1_cmd_i;
		if (init_busy_o) begin
			cmd0.en = 1'b1;
			cmd0.we = 1'b1;
			cmd0.index = init_cnt;
			cmd0.wdata = '0;
		end
		cmd1.en = port1_cmd_i.en & ~init_busy_o;
	end

	// ----------------------------------------------------------------------
	// array, port 1 is the later writer on a same-index collision
	// ----------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (cmd0.en && cmd0.we) begin
			mem[cmd0.index] <= cmd0.wdata;
		end
		if (cmd1.en && cmd1.we) begin
			mem[cmd1.index] <= cmd1.wdata;
		end
	end

	// write-first read ports
	always_ff @(posedge clk) begin
		if (cmd0.en) begin
			port0_rdata_o <= cmd0.we ? cmd0.wdata : mem[cmd0.index];
		end
		if (cmd1.en) begin
			port1_rdata_o <= cmd1.we ? cmd1.wdata : mem[cmd1.index];
		end
	end

endmodule

/* src/cache_word_lane.sv */
// cache line word lane select and merge

`timescale 1ns/10ps

module cache_word_lane (
	input  logic [cache_pkg::LINE_WIDTH-1:0]   line_i,
	input  logic [cache_pkg::LINE_SIZE-1:0]    offset_i,
	input  logic                               endian_i,
	input  logic [cache_pkg::DATA_WIDTH-1:0]   wdata_i,
	input  logic [cache_pkg::SEL_WIDTH-1:0]    sel_i,
	output logic [cache_pkg::DATA_WIDTH-1:0]   word_o,
	output logic [cache_pkg::LINE_WIDTH-1:0]   merged_line_o,
	output logic [cache_pkg::WB_SEL_WIDTH-1:0] wb_sel_o
);

	logic [cache_pkg::LINE_SIZE-1:0] lane;

	// ----------------------------------------------------------------------
	// lane mapping
	// ----------------------------------------------------------------------

	// endian 1 mirrors the word order, LINE_WORDS-1-offset
	assign lane = endian_i ? ~offset_i : offset_i;

	assign word_o = line_i[lane*cache_pkg::DATA_WIDTH +: cache_pkg::DATA_WIDTH];

	// ----------------------------------------------------------------------
	// byte merge and line select
	// ----------------------------------------------------------------------

	always_comb begin
		merged_line_o = line_i;
		for (int b = 0; b < cache_pkg::SEL_WIDTH; b++) begin
			if (sel_i[b]) begin
				merged_line_o[lane*cache_pkg::DATA_WIDTH + b*8 +: 8] = wdata_i[b*8 +: 8];
			end
		end
	end

	// word selects land in the same lane of the line selects
	always_comb begin
		wb_sel_o = '0;
		wb_sel_o[lane*cache_pkg::SEL_WIDTH +: cache_pkg::SEL_WIDTH] = sel_i;
	end

endmodule

/* src/cache_port_ctrl.sv */
// cache port controller

`timescale 1ns/10ps

module cache_port_ctrl (
	input  logic                             clk,
	input  logic                             RESET_INIT_RAM,
	input  logic                             init_busy_i,
	input  logic                             endian_i,
	input  cache_pkg::cache_req_t            req_i,
	output logic [cache_pkg::DATA_WIDTH-1:0] rdata_o,
	output logic                             ready_o,
	output cache_pkg::ram_cmd_t              ram_cmd_o,
	input  cache_pkg::line_entry_t           ram_rdata_i,
	output cache_pkg::wb_req_t               wb_o,
	input  logic [cache_pkg::LINE_WIDTH-1:0] wb_dat_i,
	input  logic                             wb_ack_i
);

	cache_pkg::port_state_t state;
	cache_pkg::cache_req_t req_q;

	logic [cache_pkg::LINE_WIDTH-1:0] line_q;
	logic hit_q;

	logic [cache_pkg::TAG_WIDTH-1:0] tag_q;
	logic [cache_pkg::INDEX_WIDTH-1:0] index_q;
	logic [cache_pkg::LINE_SIZE-1:0] offset_q;
	logic [cache_pkg::INDEX_WIDTH-1:0] req_index;
	logic accept;
	logic hit;

	logic [cache_pkg::LINE_WIDTH-1:0] lane_line;
	logic [cache_pkg::LINE_WIDTH-1:0] merged_line;
	logic [cache_pkg::WB_SEL_WIDTH-1:0] lane_sel;

	// ----------------------------------------------------------------------
	// address split and hit check
	// ----------------------------------------------------------------------

	assign offset_q = req_q.addr[cache_pkg::LINE_SIZE-1:0];
	assign index_q = req_q.addr[cache_pkg::LINE_SIZE +: cache_pkg::INDEX_WIDTH];
	assign tag_q = req_q.addr[cache_pkg::ADDR_WIDTH-1 -: cache_pkg::TAG_WIDTH];
	assign req_index = req_i.addr[cache_pkg::LINE_SIZE +: cache_pkg::INDEX_WIDTH];

	// nothing accepted until the valid sweep is over
	assign accept = (state == cache_pkg::IDLE) && req_i.valid && !init_busy_i;

	assign hit = ram_rdata_i.valid && (ram_rdata_i.tag == tag_q);

	// merge works on the RAM line while in LOOKUP
	assign lane_line = (state == cache_pkg::LOOKUP) ? ram_rdata_i.data : line_q;

	cache_word_lane i_word_lane (
		.line_i        (lane_line),
		.offset_i      (offset_q),
		.endian_i      (endian_i),
		.wdata_i       (req_q.wdata),
		.sel_i         (req_q.sel),
		.word_o        (rdata_o),
		.merged_line_o (merged_line),
		.wb_sel_o      (lane_sel)
	);

	// ----------------------------------------------------------------------
	// FSM
	// ----------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (RESET_INIT_RAM) begin
			state <= cache_pkg::IDLE;
		end else begin
			case (state)
				cache_pkg::IDLE: begin
					if (accept) begin
						state <= cache_pkg::LOOKUP;
					end
				end
				cache_pkg::LOOKUP: begin
					if (req_q.we) begin
						state <= cache_pkg::WRITE;
					end else if (hit) begin
						state <= cache_pkg::DONE;
					end else begin
						state <= cache_pkg::REFILL;
					end
				end
				cache_pkg::REFILL, cache_pkg::WRITE: begin
					if (wb_ack_i) begin
						state <= cache_pkg::DONE;
					end
				end
				default: begin
					state <= cache_pkg::IDLE;
				end
			endcase
		end
	end

	// request and line payload
	always_ff @(posedge clk) begin
		if (accept) begin
			req_q <= req_i;
		end
		if (state == cache_pkg::LOOKUP) begin
			line_q <= req_q.we ? merged_line : ram_rdata_i.data;
			hit_q <= hit;
		end
		if (state == cache_pkg::REFILL && wb_ack_i) begin
			line_q <= wb_dat_i;
		end
	end

	assign ready_o = (state == cache_pkg::DONE);

	// ----------------------------------------------------------------------
	// RAM and wishbone requests
	// ----------------------------------------------------------------------

	always_comb begin
		ram_cmd_o = '0;
		ram_cmd_o.wdata.valid = 1'b1;
		ram_cmd_o.wdata.tag = tag_q;
		ram_cmd_o.wdata.data = line_q;
		if (state == cache_pkg::IDLE) begin
			ram_cmd_o.en = accept;
			ram_cmd_o.index = req_index;
		end else begin
			ram_cmd_o.index = index_q;
		end
		if (state == cache_pkg::REFILL && wb_ack_i) begin
			ram_cmd_o.en = 1'b1;
			ram_cmd_o.we = 1'b1;
			ram_cmd_o.wdata.data = wb_dat_i;
		end
		// write hit keeps the cached line current
		if (state == cache_pkg::WRITE && wb_ack_i && hit_q) begin
			ram_cmd_o.en = 1'b1;
			ram_cmd_o.we = 1'b1;
		end
	end

	always_comb begin
		wb_o.stb = (state == cache_pkg::REFILL) || (state == cache_pkg::WRITE);
		wb_o.we = (state == cache_pkg::WRITE);
		wb_o.adr = req_q.addr[cache_pkg::ADDR_WIDTH-1:cache_pkg::LINE_SIZE];
		wb_o.dat = line_q;
		wb_o.sel = wb_o.we ? lane_sel : '1;
	end

endmodule

/* src/wb_arbiter.sv */
// two master wishbone arbiter

`timescale 1ns/10ps

module wb_arbiter (
	input  logic                             clk,
	input  logic                             RESET_INIT_RAM,
	input  cache_pkg::wb_req_t               s0_i,
	output logic [cache_pkg::LINE_WIDTH-1:0] s0_dat_o,
	output logic                             s0_ack_o,
	input  cache_pkg::wb_req_t               s1_i,
	output logic [cache_pkg::LINE_WIDTH-1:0] s1_dat_o,
	output logic                             s1_ack_o,
	output cache_pkg::wb_req_t               m_o,
	input  logic [cache_pkg::LINE_WIDTH-1:0] m_dat_i,
	input  logic                             m_ack_i
);

	logic grant_valid;
	logic grant_sel;
	logic last_sel;
	logic next_sel;

	// ----------------------------------------------------------------------
	// round robin grant
	// ----------------------------------------------------------------------

	// both asking: the one not served last wins
	always_comb begin
		if (s0_i.stb && s1_i.stb) begin
			next_sel = ~last_sel;
		end else begin
			next_sel = s1_i.stb;
		end
	end

	always_ff @(posedge clk) begin
		if (RESET_INIT_RAM) begin
			grant_valid <= 1'b0;
			grant_sel <= 1'b0;
			last_sel <= 1'b1;
		end else if (grant_valid) begin
			if (m_ack_i) begin
				grant_valid <= 1'b0;
				last_sel <= grant_sel;
			end
		end else if (s0_i.stb || s1_i.stb) begin
			grant_valid <= 1'b1;
			grant_sel <= next_sel;
		end
	end

	// ----------------------------------------------------------------------
	// routing
	// ----------------------------------------------------------------------

	always_comb begin
		m_o = grant_sel ? s1_i : s0_i;
		m_o.stb = grant_valid & (grant_sel ? s1_i.stb : s0_i.stb);
	end

	assign s0_ack_o = m_ack_i & grant_valid & ~grant_sel;
	assign s1_ack_o = m_ack_i & grant_valid & grant_sel;
	assign s0_dat_o = s0_ack_o ? m_dat_i : '0;
	assign s1_dat_o = s1_ack_o ? m_dat_i : '0;

endmodule

/* src/cache_unified.sv */
// unified two port cache top

`timescale 1ns/10ps

module cache_unified (
	input  logic                             clk,
	input  logic                             RESET_INIT_RAM,
	input  logic                             endian_i,
	input  cache_pkg::cache_req_t            port0_req_i,
	output logic [cache_pkg::DATA_WIDTH-1:0] port0_rdata_o,
	output logic                             port0_ready_o,
	input  cache_pkg::cache_req_t            port1_req_i,
	output logic [cache_pkg::DATA_WIDTH-1:0] port1_rdata_o,
	output logic                             port1_ready_o,
	output cache_pkg::wb_req_t               m_wb_o,
	input  logic [cache_pkg::LINE_WIDTH-1:0] m_wb_dat_i,
	input  logic                             m_wb_ack_i
);

	logic init_busy;

	cache_pkg::ram_cmd_t ram0_cmd;
	cache_pkg::ram_cmd_t ram1_cmd;
	cache_pkg::line_entry_t ram0_rdata;
	cache_pkg::line_entry_t ram1_rdata;

	cache_pkg::wb_req_t wb0_req;
	cache_pkg::wb_req_t wb1_req;
	logic [cache_pkg::LINE_WIDTH-1:0] wb0_dat;
	logic [cache_pkg::LINE_WIDTH-1:0] wb1_dat;
	logic wb0_ack;
	logic wb1_ack;

	// ----------------------------------------------------------------------
	// port controllers
	// ----------------------------------------------------------------------

	cache_port_ctrl i_port_ctrl_0 (
		.clk            (clk),
		.RESET_INIT_RAM (RESET_INIT_RAM),
		.init_busy_i    (init_busy),
		.endian_i       (endian_i),
		.req_i          (port0_req_i),
		.rdata_o        (port0_rdata_o),
		.ready_o        (port0_ready_o),
		.ram_cmd_o      (ram0_cmd),
		.ram_rdata_i    (ram0_rdata),
		.wb_o           (wb0_req),
		.wb_dat_i       (wb0_dat),
		.wb_ack_i       (wb0_ack)
	);

	cache_port_ctrl i_port_ctrl_1 (
		.clk            (clk),
		.RESET_INIT_RAM (RESET_INIT_RAM),
		.init_busy_i    (init_busy),
		.endian_i       (endian_i),
		.req_i          (port1_req_i),
		.rdata_o        (port1_rdata_o),
		.ready_o        (port1_ready_o),
		.ram_cmd_o      (ram1_cmd),
		.ram_rdata_i    (ram1_rdata),
		.wb_o           (wb1_req),
		.wb_dat_i       (wb1_dat),
		.wb_ack_i       (wb1_ack)
	);

	// ----------------------------------------------------------------------
	// shared line RAM and bus
	// ----------------------------------------------------------------------

	cache_line_ram i_line_ram (
		.clk            (clk),
		.RESET_INIT_RAM (RESET_INIT_RAM),
		.port0_cmd_i    (ram0_cmd),
		.port0_rdata_o  (ram0_rdata),
		.port1_cmd_i    (ram1_cmd),
		.port1_rdata_o  (ram1_rdata),
		.init_busy_o    (init_busy)
	);

	wb_arbiter i_wb_arbiter (
		.clk            (clk),
		.RESET_INIT_RAM (RESET_INIT_RAM),
		.s0_i           (wb0_req),
		.s0_dat_o       (wb0_dat),
		.s0_ack_o       (wb0_ack),
		.s1_i           (wb1_req),
		.s1_dat_o       (wb1_dat),
		.s1_ack_o       (wb1_ack),
		.m_o            (m_wb_o),
		.m_dat_i        (m_wb_dat_i),
		.m_ack_i        (m_wb_ack_i)
	);

endmodule

/* test/wb_mem_model.sv */
// wishbone line memory model

`timescale 1ns/10ps

module wb_mem_model (
	input  logic                             clk,
	input  logic                             RESET_INIT_RAM,
	input  cache_pkg::wb_req_t               wb_i,
	output logic [cache_pkg::LINE_WIDTH-1:0] dat_o,
	output logic                             ack_o
);

	// written bytes are kept for the low 1024 line addresses
	logic [cache_pkg::LINE_WIDTH-1:0]   wr_data [1024];
	logic [cache_pkg::WB_SEL_WIDTH-1:0] wr_mask [1024];
	logic [9:0] slot;
	logic       busy;
	logic [1:0] wait_cnt;
	integer     seed;
	integer     rnd;

	initial begin
		seed = 77;
		ack_o = 1'b0;
		dat_o = '0;
		for (int i = 0; i < 1024; i++) begin
			wr_data[i] = '0;
			wr_mask[i] = '0;
		end
	end

	// lane pattern from the line address, written bytes on top
	function automatic logic [cache_pkg::LINE_WIDTH-1:0] read_line(
		input logic [cache_pkg::WB_ADR_WIDTH-1:0] adr
	);
		logic [cache_pkg::LINE_WIDTH-1:0] line;
		for (int j = 0; j < cache_pkg::LINE_WORDS; j++) begin
			line[j*32 +: 32] = {6'd0, adr, 4'd0} + 32'hA500_0000 + j;
		end
		for (int b = 0; b < cache_pkg::WB_SEL_WIDTH; b++) begin
			if (wr_mask[adr[9:0]][b]) begin
				line[b*8 +: 8] = wr_data[adr[9:0]][b*8 +: 8];
			end
		end
		return line;
	endfunction

	assign slot = wb_i.adr[9:0];

	// ----------------------------------------------------------------------
	// one beat per strobe, ack after 1 to 4 cycles
	// ----------------------------------------------------------------------

	always @(posedge clk) begin
		ack_o <= 1'b0;
		if (RESET_INIT_RAM) begin
			busy <= 1'b0;
			wait_cnt <= '0;
		end else if (busy) begin
			if (wait_cnt == 0) begin
				ack_o <= 1'b1;
				busy <= 1'b0;
				dat_o <= read_line(wb_i.adr);
				if (wb_i.we) begin
					for (int b = 0; b < cache_pkg::WB_SEL_WIDTH; b++) begin
						if (wb_i.sel[b]) begin
							wr_data[slot][b*8 +: 8] <= wb_i.dat[b*8 +: 8];
							wr_mask[slot][b] <= 1'b1;
						end
					end
				end
			end else begin
				wait_cnt <= wait_cnt - 1'b1;
			end
		end else if (wb_i.stb && !ack_o) begin
			rnd = $random(seed);
			busy <= 1'b1;
			wait_cnt <= rnd[1:0];
		end
	end

endmodule

/* test/cache_unified_tb.sv */
// unified cache testbench

`timescale 1ns/10ps

module cache_unified_tb;

	localparam int NUM_TESTS = 23;
	localparam int WAIT_LIMIT = 40;
	localparam int CYCLE_LIMIT = NUM_TESTS * 40 + 16 + 20;

	typedef struct packed {
		logic                                port;
		logic                                paired;
		logic                                we;
		logic [cache_pkg::ADDR_WIDTH-1:0]    addr;
		logic [cache_pkg::DATA_WIDTH-1:0]    wdata;
		logic [cache_pkg::SEL_WIDTH-1:0]     sel;
		logic                                endian;
		logic                                bus_rd;
	} test_entry_t;

	logic clk;
	logic RESET_INIT_RAM;
	logic endian;
	cache_pkg::cache_req_t port0_req;
	cache_pkg::cache_req_t port1_req;
	logic [cache_pkg::DATA_WIDTH-1:0] port0_rdata;
	logic [cache_pkg::DATA_WIDTH-1:0] port1_rdata;
	logic port0_ready;
	logic port1_ready;
	cache_pkg::wb_req_t m_wb;
	logic [cache_pkg::LINE_WIDTH-1:0] m_wb_dat;
	logic m_wb_ack;

	test_entry_t test_table [NUM_TESTS];
	int table_len = 0;
	int cycle_cnt = 0;
	int bus_reads = 0;
	int bus_writes = 0;
	int pass_cnt = 0;
	int fail_cnt = 0;
	int entry_errors;
	logic [cache_pkg::WB_ADR_WIDTH-1:0] last_wr_adr;
	logic [cache_pkg::WB_SEL_WIDTH-1:0] last_wr_sel;
	logic [cache_pkg::LINE_WIDTH-1:0]   last_wr_dat;

	// reference copy of the bytes written to memory
	logic [cache_pkg::LINE_WIDTH-1:0]   ref_data [1024];
	logic [cache_pkg::WB_SEL_WIDTH-1:0] ref_mask [1024];

	cache_unified dut0 (
		.clk            (clk),
		.RESET_INIT_RAM (RESET_INIT_RAM),
		.endian_i       (endian),
		.port0_req_i    (port0_req),
		.port0_rdata_o  (port0_rdata),
		.port0_ready_o  (port0_ready),
		.port1_req_i    (port1_req),
		.port1_rdata_o  (port1_rdata),
		.port1_ready_o  (port1_ready),
		.m_wb_o         (m_wb),
		.m_wb_dat_i     (m_wb_dat),
		.m_wb_ack_i     (m_wb_ack)
	);

	wb_mem_model i_mem (
		.clk            (clk),
		.RESET_INIT_RAM (RESET_INIT_RAM),
		.wb_i           (m_wb),
		.dat_o          (m_wb_dat),
		.ack_o          (m_wb_ack)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#20 clk = ~clk;
		end
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= CYCLE_LIMIT) begin
			$display("timeout after %0d cycles, the tests did not finish", cycle_cnt);
			$display("Regression failed");
			$finish;
		end
	end

	// bus monitor
	always @(negedge clk) begin
		if (m_wb.stb && m_wb_ack) begin
			if (m_wb.we) begin
				bus_writes = bus_writes + 1;
				last_wr_adr = m_wb.adr;
				last_wr_sel = m_wb.sel;
				last_wr_dat = m_wb.dat;
			end else begin
				bus_reads = bus_reads + 1;
			end
		end
	end

	// ----------------------------------------------------------------------
	// expected values
	// ----------------------------------------------------------------------

	function automatic int lane_of(
		input logic [cache_pkg::ADDR_WIDTH-1:0] addr,
		input logic                             endian_sel
	);
		int offset;
		offset = addr[1:0];
		if (endian_sel) begin
			return cache_pkg::LINE_WORDS - 1 - offset;
		end
		return offset;
	endfunction

	function automatic logic [31:0] model_word(input logic [21:0] line_adr, input int lane);
		logic [31:0] word;
		word = {6'd0, line_adr, 4'd0} + 32'hA500_0000 + lane;
		for (int b = 0; b < 4; b++) begin
			if (ref_mask[line_adr[9:0]][lane*4 + b]) begin
				word[b*8 +: 8] = ref_data[line_adr[9:0]][lane*32 + b*8 +: 8];
			end
		end
		return word;
	endfunction

	task automatic store_ref(input test_entry_t e);
		int lane;
		logic [9:0] slot;
		lane = lane_of(e.addr, e.endian);
		slot = e.addr[11:2];
		for (int b = 0; b < 4; b++) begin
			if (e.sel[b]) begin
				ref_data[slot][lane*32 + b*8 +: 8] = e.wdata[b*8 +: 8];
				ref_mask[slot][lane*4 + b] = 1'b1;
			end
		end
	endtask

	task automatic add_entry(
		input logic port, input logic paired, input logic we, input logic [23:0] addr,
		input logic [31:0] wdata, input logic [3:0] sel, input logic endian_sel,
		input logic bus_rd
	);
		test_table[table_len] = {port, paired, we, addr, wdata, sel, endian_sel, bus_rd};
		table_len++;
	endtask

	// ----------------------------------------------------------------------
	// request and check
	// ----------------------------------------------------------------------

	task automatic run_request(
		input test_entry_t e, output logic [31:0] rdata, output bit got_ready
	);
		cache_pkg::cache_req_t req;
		int waited;
		req.valid = 1'b1;
		req.we = e.we;
		req.addr = e.addr;
		req.wdata = e.wdata;
		req.sel = e.sel;
		got_ready = 1'b0;
		rdata = '0;
		waited = 0;
		if (e.port) begin
			port1_req = req;
		end else begin
			port0_req = req;
		end
		while (!got_ready && waited < WAIT_LIMIT) begin
			@(negedge clk);
			waited++;
			if (e.port ? port1_ready : port0_ready) begin
				got_ready = 1'b1;
				rdata = e.port ? port1_rdata : port0_rdata;
			end
		end
		if (e.port) begin
			port1_req = '0;
		end else begin
			port0_req = '0;
		end
	endtask

	task automatic check_request(input test_entry_t e, input logic [31:0] rdata, input bit ok);
		int lane;
		logic [31:0] exp_word;
		logic [15:0] exp_sel;
		lane = lane_of(e.addr, e.endian);
		if (!ok) begin
			$display("port %0d gave no ready within %0d cycles", e.port, WAIT_LIMIT);
			entry_errors++;
		end else if (e.we) begin
			exp_sel = {12'h000, e.sel} << (lane * 4);
			if (last_wr_adr != e.addr[23:2]) begin
				$display("FAILED m_wb_o.adr exp %h got %h", e.addr[23:2], last_wr_adr);
				entry_errors++;
			end
			if (last_wr_sel != exp_sel) begin
				$display("FAILED m_wb_o.sel exp %h got %h", exp_sel, last_wr_sel);
				entry_errors++;
			end
			// written bytes sit in the lane of the line
			for (int b = 0; b < 4; b++) begin
				if (e.sel[b] && last_wr_dat[lane*32 + b*8 +: 8] != e.wdata[b*8 +: 8]) begin
					$display("FAILED m_wb_o.dat byte %0d exp %h got %h", lane*4 + b,
						e.wdata[b*8 +: 8], last_wr_dat[lane*32 + b*8 +: 8]);
					entry_errors++;
				end
			end
			store_ref(e);
		end else begin
			exp_word = model_word(e.addr[23:2], lane);
			if (rdata != exp_word) begin
				$display("FAILED port%0d_rdata_o exp %h got %h", e.port, exp_word, rdata);
				entry_errors++;
			end
		end
	endtask

	// ----------------------------------------------------------------------
	// main sequence
	// ----------------------------------------------------------------------

	initial begin
		test_entry_t e0;
		test_entry_t e1;
		bit paired;
		bit ok0;
		bit ok1;
		logic [31:0] rdata0;
		logic [31:0] rdata1;
		int idx;
		int rd_start;
		int wr_start;
		int exp_reads;
		int exp_writes;
		RESET_INIT_RAM = 1'b1;
		endian = 1'b0;
		port0_req = '0;
		port1_req = '0;
		for (int i = 0; i < 1024; i++) begin
			ref_data[i] = '0;
			ref_mask[i] = '0;
		end
		// port paired we addr wdata sel endian bus_rd
		add_entry(0, 0, 0, 24'h000010, 32'h0, 4'h0, 0, 1);
		add_entry(0, 0, 0, 24'h000011, 32'h0, 4'h0, 0, 0);
		add_entry(0, 0, 0, 24'h000013, 32'h0, 4'h0, 0, 0);
		add_entry(1, 0, 0, 24'h000012, 32'h0, 4'h0, 0, 0);
		add_entry(0, 0, 1, 24'h000011, 32'h11223344, 4'h6, 0, 0);
		add_entry(0, 0, 0, 24'h000011, 32'h0, 4'h0, 0, 0);
		// write miss does not allocate
		add_entry(1, 0, 1, 24'h000020, 32'hdeadbeef, 4'hf, 0, 0);
		add_entry(1, 0, 0, 24'h000020, 32'h0, 4'h0, 0, 1);
		// index 4 with tags 0 and 1
		add_entry(0, 0, 0, 24'h000050, 32'h0, 4'h0, 0, 1);
		add_entry(0, 0, 0, 24'h000011, 32'h0, 4'h0, 0, 1);
		add_entry(0, 0, 0, 24'h000052, 32'h0, 4'h0, 0, 1);
		add_entry(0, 0, 0, 24'h000013, 32'h0, 4'h0, 0, 1);
		add_entry(0, 1, 0, 24'h000030, 32'h0, 4'h0, 0, 1);
		add_entry(1, 0, 0, 24'h000074, 32'h0, 4'h0, 0, 1);
		add_entry(0, 1, 0, 24'h000031, 32'h0, 4'h0, 0, 0);
		add_entry(1, 0, 0, 24'h000077, 32'h0, 4'h0, 0, 0);
		// mirrored word order
		add_entry(0, 0, 0, 24'h000031, 32'h0, 4'h0, 1, 0);
		add_entry(1, 0, 0, 24'h000090, 32'h0, 4'h0, 1, 1);
		add_entry(1, 0, 1, 24'h000091, 32'hcafef00d, 4'h3, 1, 0);
		add_entry(1, 0, 0, 24'h000091, 32'h0, 4'h0, 1, 0);
		add_entry(0, 0, 0, 24'h000092, 32'h0, 4'h0, 0, 0);
		add_entry(0, 0, 1, 24'h000093, 32'h77000000, 4'h8, 1, 0);
		add_entry(0, 0, 0, 24'h000090, 32'h0, 4'h0, 0, 0);

		repeat (3) @(posedge clk);
		@(negedge clk);
		RESET_INIT_RAM = 1'b0;

		// held requests on both ports must not be taken during the sweep
		entry_errors = 0;
		port0_req.valid = 1'b1;
		port0_req.addr = 24'h000010;
		port1_req.valid = 1'b1;
		port1_req.addr = 24'h000020;
		repeat (16) begin
			@(negedge clk);
			if (port0_ready || port1_ready || m_wb.stb) begin
				$display("FAILED ready_o/m_wb_o.stb exp %h got %h", 3'h0,
					{port0_ready, port1_ready, m_wb.stb});
				entry_errors++;
			end
		end
		port0_req = '0;
		port1_req = '0;
		if (entry_errors == 0) begin
			pass_cnt++;
			$display("test sweep ok");
		end else begin
			fail_cnt++;
			$display("test sweep failed");
		end

		idx = 0;
		while (idx < table_len) begin
			e0 = test_table[idx];
			paired = e0.paired;
			e1 = paired ? test_table[idx + 1] : '0;
			endian = e0.endian;
			rd_start = bus_reads;
			wr_start = bus_writes;
			entry_errors = 0;
			if (paired) begin
				fork
					run_request(e0, rdata0, ok0);
					run_request(e1, rdata1, ok1);
				join
			end else begin
				run_request(e0, rdata0, ok0);
			end
			check_request(e0, rdata0, ok0);
			if (paired) begin
				check_request(e1, rdata1, ok1);
			end
			exp_reads = e0.bus_rd + (paired ? e1.bus_rd : 0);
			exp_writes = e0.we + (paired ? e1.we : 0);
			if (bus_reads - rd_start != exp_reads) begin
				$display("FAILED wb_reads exp %h got %h", exp_reads, bus_reads - rd_start);
				entry_errors++;
			end
			if (bus_writes - wr_start != exp_writes) begin
				$display("FAILED wb_writes exp %h got %h", exp_writes, bus_writes - wr_start);
				entry_errors++;
			end
			if (entry_errors == 0) begin
				pass_cnt++;
				$display("test %0d addr %h ok", idx, e0.addr);
			end else begin
				fail_cnt++;
				$display("test %0d addr %h failed", idx, e0.addr);
			end
			idx += paired ? 2 : 1;
		end

		$display("tests %0d, passed %0d, failed %0d", pass_cnt + fail_cnt, pass_cnt, fail_cnt);
		if (fail_cnt == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

/* cache_unified.f */
src/cache_pkg.sv
src/cache_line_ram.sv
src/cache_word_lane.sv
src/cache_port_ctrl.sv
src/wb_arbiter.sv
src/cache_unified.sv
test/wb_mem_model.sv
test/cache_unified_tb.sv
